//--- logic/can_pkg.sv
// CAN codec shared definitions
package can_pkg;

    // Field of the frame being sent or received
    typedef enum logic [4:0] {
        IDLE,
        SOF,
        ID_A,
        SRR,
        IDE,
        ID_B,
        RTR,
        R1,
        R0,
        DLC,
        DATA,
        CRC,
        CRC_DEL,
        ACK_SLOT,
        ACK_DEL,
        EOF,
        IFS
    } can_field_e;

    // Identifier word, read as extended or as standard
    typedef union packed {
        struct packed {
            logic [10:0] base;
            logic [17:0] extn;
        } ext_view;
        struct packed {
            logic [17:0] pad;
            logic [10:0] sid;
        } std_view;
    } can_id_u;

    localparam logic [14:0] CRC_POLY = 15'h4599;
    localparam int STUFF_LIMIT = 5;
    localparam int EOF_BITS    = 7;
    localparam int IFS_BITS    = 3;
    localparam int IDLE_BITS   = 11;
    localparam int MAX_BYTES   = 8;

endpackage

//--- logic/can_frame_if.sv
// CAN frame handshake interface
`timescale 1ns/100ps

interface can_frame_if;
    import can_pkg::*;

    logic        req;
    logic        ack;
    can_id_u     id;
    logic        rtr;
    logic [3:0]  dlc;
    // Byte 0 in the top byte
    logic [63:0] data;

    modport sender (
        output req, id, rtr, dlc, data,
        input  ack
    );

    modport receiver (
        input  req, id, rtr, dlc, data,
        output ack
    );

endinterface

//--- logic/can_crc15.sv
// Serial CRC-15 register
`timescale 1ns/100ps

module can_crc15 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        init,
    input  logic        en,
    input  logic        bit_in,
    output logic [14:0] crc
);
    import can_pkg::*;

    logic feedback;

    assign feedback = bit_in ^ crc[14];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (init) begin
            crc <= '0;
        end else if (en) begin
            // Shift left, fold in the polynomial on a mismatch
            crc <= {crc[13:0], 1'b0} ^ (feedback ? CRC_POLY : 15'h0000);
        end
    end

endmodule

//--- logic/can_tx.sv
// CAN frame transmitter
`timescale 1ns/100ps

module can_tx #(
    parameter bit ext_id = 1'b0
) (
    input  logic          clk,
    input  logic          rst_n,
    can_frame_if.receiver frame,
    output logic          can_tx
);
    import can_pkg::*;

    can_field_e  field;
    can_field_e  nxt_field;
    logic [5:0]  cnt;
    logic [5:0]  nxt_cnt;
    logic        last;
    logic        nxt_bit;
    logic [2:0]  run;
    logic        stuff;
    logic        in_frame;
    logic [3:0]  nbytes;
    logic [2:0]  last_byte;
    logic [14:0] crc;
    logic        crc_init;
    logic        crc_en;

    // Payload length in bytes, remote frames carry none
    assign nbytes    = frame.rtr ? 4'd0 :
                       (frame.dlc > 4'(MAX_BYTES)) ? 4'(MAX_BYTES) : frame.dlc;
    assign last_byte = 3'(4'(MAX_BYTES) - nbytes);

    // Counters run down, data stops at the last sent byte
    assign last = (field == DATA) ? (cnt == {last_byte, 3'b000}) : (cnt == 6'd0);

    // field and cnt describe the bit now on the line
    assign in_frame = field inside {[SOF:CRC_DEL]};
    assign stuff    = (field inside {[SOF:CRC]}) && (run == 3'(STUFF_LIMIT));

    always_comb begin
        nxt_field = field;
        nxt_cnt   = '0;
        if (!last) begin
            nxt_cnt = cnt - 6'd1;
        end else begin
            case (field)
                IDLE: if (frame.req && !frame.ack) nxt_field = SOF;
                SOF: begin
                    nxt_field = ID_A;
                    nxt_cnt   = 6'd10;
                end
                ID_A: nxt_field = ext_id ? SRR : RTR;
                SRR: nxt_field = IDE;
                IDE: begin
                    nxt_field = ext_id ? ID_B : R0;
                    nxt_cnt   = ext_id ? 6'd17 : 6'd0;
                end
                ID_B: nxt_field = RTR;
                // Standard frames put IDE after RTR
                RTR: nxt_field = ext_id ? R1 : IDE;
                R1: nxt_field = R0;
                R0: begin
                    nxt_field = DLC;
                    nxt_cnt   = 6'd3;
                end
                DLC: begin
                    nxt_field = (nbytes != 4'd0) ? DATA : CRC;
                    nxt_cnt   = (nbytes != 4'd0) ? 6'd63 : 6'd14;
                end
                DATA: begin
                    nxt_field = CRC;
                    nxt_cnt   = 6'd14;
                end
                CRC: nxt_field = CRC_DEL;
                CRC_DEL: nxt_field = ACK_SLOT;
                ACK_SLOT: nxt_field = ACK_DEL;
                ACK_DEL: begin
                    nxt_field = EOF;
                    nxt_cnt   = 6'(EOF_BITS - 1);
                end
                EOF: begin
                    nxt_field = IFS;
                    nxt_cnt   = 6'(IFS_BITS - 1);
                end
                default: nxt_field = IDLE;
            endcase
        end
    end

    // Line level of the next unstuffed bit
    always_comb begin
        case (nxt_field)
            SOF, R1, R0: nxt_bit = 1'b0;
            ID_A: nxt_bit = ext_id ? frame.id.ext_view.base[nxt_cnt[3:0]]
                                   : frame.id.std_view.sid[nxt_cnt[3:0]];
            SRR:  nxt_bit = 1'b1;
            IDE:  nxt_bit = ext_id;
            ID_B: nxt_bit = frame.id.ext_view.extn[nxt_cnt[4:0]];
            RTR:  nxt_bit = frame.rtr;
            DLC:  nxt_bit = frame.dlc[nxt_cnt[1:0]];
            DATA: nxt_bit = frame.data[nxt_cnt];
            CRC:  nxt_bit = crc[nxt_cnt[3:0]];
            default: nxt_bit = 1'b1;
        endcase
    end

    assign crc_init = (field == IDLE) && (nxt_field == IDLE);
    assign crc_en   = !stuff && (nxt_field inside {[SOF:DATA]});

    can_crc15 crc_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .init   (crc_init),
        .en     (crc_en),
        .bit_in (nxt_bit),
        .crc    (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field     <= IDLE;
            cnt       <= '0;
            run       <= '0;
            can_tx    <= 1'b1;
            frame.ack <= 1'b0;
        end else begin
            if (stuff) begin
                // Complement, counters hold for this cycle
                can_tx <= !can_tx;
                run    <= 3'd1;
            end else begin
                field  <= nxt_field;
                cnt    <= nxt_cnt;
                can_tx <= nxt_bit;
                if (nxt_bit != can_tx) begin
                    run <= 3'd1;
                end else if (run != 3'd7) begin
                    run <= run + 3'd1;
                end
            end
            if (field == IFS && nxt_field == IDLE) begin
                frame.ack <= 1'b1;
            end else if (!frame.req) begin
                frame.ack <= 1'b0;
            end
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(frame.ack) |-> frame.req);

    // No run of six equal line bits inside the stuffed part
    a_no_six_equal: assert property (@(posedge clk) disable iff (!rst_n)
        in_frame && $past(in_frame, 5) |->
            !({can_tx, $past(can_tx, 1), $past(can_tx, 2), $past(can_tx, 3),
               $past(can_tx, 4), $past(can_tx, 5)} inside {6'h00, 6'h3f}));

endmodule

//--- logic/can_rx.sv
// CAN frame receiver
`timescale 1ns/100ps

module can_rx #(
    parameter bit ext_id = 1'b0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        can_rx,
    can_frame_if.sender frame,
    output logic        crc_err
);
    import can_pkg::*;

    can_field_e  field;
    can_field_e  nxt_field;
    logic [5:0]  cnt;
    logic [5:0]  nxt_cnt;
    logic        last;
    logic [3:0]  idle_cnt;
    logic        armed;
    logic        start;
    logic        destuff;
    logic        take;
    logic        zone;
    logic [2:0]  run;
    logic        last_bit;
    logic [3:0]  dlc_now;
    logic [3:0]  nbytes;
    logic [2:0]  last_byte;
    logic [14:0] crc_rx;
    logic [14:0] crc;
    logic        crc_init;
    logic        crc_en;

    assign armed   = idle_cnt == 4'(IDLE_BITS);
    // A frame still waiting for the host blocks the next SOF
    assign start   = (field == IDLE) && armed && !can_rx && !frame.req && !frame.ack;
    assign destuff = (field != IDLE) && zone && (run == 3'(STUFF_LIMIT));
    assign take    = (field != IDLE) && !destuff;

    // Last DLC bit is still on the line when the length is needed
    assign dlc_now   = (field == DLC) ? {frame.dlc[3:1], can_rx} : frame.dlc;
    assign nbytes    = frame.rtr ? 4'd0 :
                       (dlc_now > 4'(MAX_BYTES)) ? 4'(MAX_BYTES) : dlc_now;
    assign last_byte = 3'(4'(MAX_BYTES) - nbytes);
    assign last      = (field == DATA) ? (cnt == {last_byte, 3'b000}) : (cnt == 6'd0);

    // field and cnt name the next expected bit
    always_comb begin
        nxt_field = field;
        nxt_cnt   = '0;
        if (!last) begin
            nxt_cnt = cnt - 6'd1;
        end else begin
            case (field)
                ID_A: nxt_field = ext_id ? SRR : RTR;
                SRR: nxt_field = IDE;
                IDE: begin
                    nxt_field = ext_id ? ID_B : R0;
                    nxt_cnt   = ext_id ? 6'd17 : 6'd0;
                end
                ID_B: nxt_field = RTR;
                RTR: nxt_field = ext_id ? R1 : IDE;
                R1: nxt_field = R0;
                R0: begin
                    nxt_field = DLC;
                    nxt_cnt   = 6'd3;
                end
                DLC: begin
                    nxt_field = (nbytes != 4'd0) ? DATA : CRC;
                    nxt_cnt   = (nbytes != 4'd0) ? 6'd63 : 6'd14;
                end
                DATA: begin
                    nxt_field = CRC;
                    nxt_cnt   = 6'd14;
                end
                CRC: nxt_field = CRC_DEL;
                CRC_DEL: nxt_field = ACK_SLOT;
                ACK_SLOT: nxt_field = ACK_DEL;
                default: nxt_field = IDLE;
            endcase
        end
    end

    assign crc_init = (field == IDLE) && !start;
    assign crc_en   = start || (take && (field inside {[ID_A:DATA]}));

    can_crc15 crc_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .init   (crc_init),
        .en     (crc_en),
        .bit_in (can_rx),
        .crc    (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field     <= IDLE;
            cnt       <= '0;
            zone      <= 1'b0;
            run       <= '0;
            last_bit  <= 1'b1;
            idle_cnt  <= 4'(IDLE_BITS);
            frame.req <= 1'b0;
            crc_err   <= 1'b0;
        end else begin
            // Idle counting goes on even while a frame is pending
            if (!can_rx) begin
                idle_cnt <= '0;
            end else if (!armed) begin
                idle_cnt <= idle_cnt + 4'd1;
            end
            if (frame.req && frame.ack) begin
                frame.req <= 1'b0;
            end

            if (start) begin
                field    <= ID_A;
                cnt      <= 6'd10;
                zone     <= 1'b1;
                run      <= 3'd1;
                last_bit <= 1'b0;
            end else if (destuff) begin
                run      <= 3'd1;
                last_bit <= can_rx;
                // sixth equal bit is a stuff error
                if (can_rx == last_bit) begin
                    field    <= IDLE;
                    zone     <= 1'b0;
                    idle_cnt <= '0;
                end
            end else if (take) begin
                field    <= nxt_field;
                cnt      <= nxt_cnt;
                zone     <= field inside {[ID_A:CRC]};
                last_bit <= can_rx;
                if (can_rx != last_bit) begin
                    run <= 3'd1;
                end else if (run != 3'd7) begin
                    run <= run + 3'd1;
                end
                // Wrong identifier format drops the frame
                if (field == IDE && can_rx != ext_id) begin
                    field    <= IDLE;
                    zone     <= 1'b0;
                    idle_cnt <= '0;
                end
                if (field == ACK_DEL) begin
                    frame.req <= 1'b1;
                    crc_err   <= crc_rx != crc;
                end
            end
        end
    end

    // Holding registers, cleared at SOF so unused bytes read zero
    always_ff @(posedge clk) begin
        if (start) begin
            frame.id   <= '0;
            frame.rtr  <= 1'b0;
            frame.dlc  <= '0;
            frame.data <= '0;
        end else if (take) begin
            case (field)
                ID_A: begin
                    if (ext_id) begin
                        frame.id.ext_view.base[cnt[3:0]] <= can_rx;
                    end else begin
                        frame.id.std_view.sid[cnt[3:0]] <= can_rx;
                    end
                end
                ID_B: frame.id.ext_view.extn[cnt[4:0]] <= can_rx;
                RTR:  frame.rtr <= can_rx;
                DLC:  frame.dlc[cnt[1:0]] <= can_rx;
                DATA: frame.data[cnt] <= can_rx;
                CRC:  crc_rx[cnt[3:0]] <= can_rx;
                default: ;
            endcase
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        frame.req && !frame.ack |=> frame.req);

    a_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        frame.req && $past(frame.req) |->
            $stable(frame.id) && $stable(frame.dlc) && $stable(frame.data));

endmodule

//--- logic/can_codec.sv
// CAN frame codec top level
`timescale 1ns/100ps

module can_codec #(
    parameter bit ext_id = 1'b0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_req,
    input  logic [28:0] tx_id,
    input  logic        tx_rtr,
    input  logic [3:0]  tx_dlc,
    input  logic [63:0] tx_data,
    input  logic        can_rx,
    input  logic        rx_ack,
    output logic        tx_ack,
    output logic        can_tx,
    output logic        rx_req,
    output logic [28:0] rx_id,
    output logic        rx_rtr,
    output logic [3:0]  rx_dlc,
    output logic [63:0] rx_data,
    output logic        rx_crc_err
);

    can_frame_if tx_frame ();
    can_frame_if rx_frame ();

    // Host side of the transmit handshake
    assign tx_frame.req  = tx_req;
    assign tx_frame.id   = tx_id;
    assign tx_frame.rtr  = tx_rtr;
    assign tx_frame.dlc  = tx_dlc;
    assign tx_frame.data = tx_data;
    assign tx_ack        = tx_frame.ack;

    can_tx #(.ext_id(ext_id)) tx_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .frame  (tx_frame.receiver),
        .can_tx (can_tx)
    );

    can_rx #(.ext_id(ext_id)) rx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .can_rx  (can_rx),
        .frame   (rx_frame.sender),
        .crc_err (rx_crc_err)
    );

    // Host side of the receive handshake
    assign rx_req       = rx_frame.req;
    assign rx_id        = rx_frame.id;
    assign rx_rtr       = rx_frame.rtr;
    assign rx_dlc       = rx_frame.dlc;
    assign rx_data      = rx_frame.data;
    assign rx_frame.ack = rx_ack;

endmodule

//--- verif/can_codec_tb.sv
// Loopback testbench for the CAN codec
`timescale 1ns/100ps

module can_codec_tb #(
    parameter bit ext_id = 1'b0
);

    localparam int N_FRAMES = 40;
    localparam int N_FLIPS  = 8;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        tx_req;
    logic [28:0] tx_id;
    logic        tx_rtr;
    logic [3:0]  tx_dlc;
    logic [63:0] tx_data;
    logic        rx_ack;
    logic        flip;
    logic        can_rx;
    logic        tx_ack;
    logic        can_tx;
    logic        rx_req;
    logic [28:0] rx_id;
    logic        rx_rtr;
    logic [3:0]  rx_dlc;
    logic [63:0] rx_data;
    logic        rx_crc_err;

    logic [15:0] lfsr_state = 16'd57881;

    // Frame being sent, and the one the receiver holds back
    logic [28:0] cur_id;
    logic        cur_rtr;
    logic [3:0]  cur_dlc;
    logic [63:0] cur_data;
    logic [28:0] held_id;
    logic        held_rtr;
    logic [3:0]  held_dlc;
    logic [63:0] held_data;

    // Model output, unstuffed and on the line
    logic raw_q[$];
    logic line_q[$];
    int   data_first;
    int   data_last;

    always #20 clk = ~clk;

    // Loopback, one line bit may be inverted
    assign can_rx = can_tx ^ flip;

    can_codec #(.ext_id(ext_id)) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_req     (tx_req),
        .tx_id      (tx_id),
        .tx_rtr     (tx_rtr),
        .tx_dlc     (tx_dlc),
        .tx_data    (tx_data),
        .can_rx     (can_rx),
        .rx_ack     (rx_ack),
        .tx_ack     (tx_ack),
        .can_tx     (can_tx),
        .rx_req     (rx_req),
        .rx_id      (rx_id),
        .rx_rtr     (rx_rtr),
        .rx_dlc     (rx_dlc),
        .rx_data    (rx_data),
        .rx_crc_err (rx_crc_err)
    );

    // Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic int byte_count(input logic rtr, input logic [3:0] dlc);
        if (rtr) begin
            return 0;
        end
        return (dlc > 4'd8) ? 8 : int'(dlc);
    endfunction

    function automatic logic [14:0] crc_step(input logic [14:0] crc, input logic b);
        logic [14:0] c;
        c = crc << 1;
        if (b != crc[14]) begin
            c = c ^ 15'h4599;
        end
        return c;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Push the low width bits of value, MSB first
    task automatic add_field(input logic [63:0] value, input int width);
        logic [63:0] v;
        v = value << (64 - width);
        repeat (width) begin
            raw_q.push_back(v[63]);
            v = v << 1;
        end
    endtask

    task automatic build_frame();
        int          nb;
        int          k;
        int          run;
        int          data_lo;
        logic        last;
        logic        b;
        logic [14:0] crc;
        raw_q.delete();
        line_q.delete();
        nb = byte_count(cur_rtr, cur_dlc);
        raw_q.push_back(1'b0);
        if (ext_id) begin
            add_field(64'(cur_id[28:18]), 11);
            // SRR and IDE recessive
            raw_q.push_back(1'b1);
            raw_q.push_back(1'b1);
            add_field(64'(cur_id[17:0]), 18);
            raw_q.push_back(cur_rtr);
            raw_q.push_back(1'b0);
            raw_q.push_back(1'b0);
        end else begin
            add_field(64'(cur_id[10:0]), 11);
            raw_q.push_back(cur_rtr);
            raw_q.push_back(1'b0);
            raw_q.push_back(1'b0);
        end
        add_field(64'(cur_dlc), 4);
        data_lo = raw_q.size();
        add_field(cur_data >> (64 - 8 * nb), 8 * nb);
        // CRC covers SOF through the data
        crc = '0;
        for (k = 0; k < raw_q.size(); k++) begin
            crc = crc_step(crc, raw_q[k]);
        end
        add_field(64'(crc), 15);
        // Stuff bits count toward the next run
        last = 1'b1;
        run  = 0;
        for (k = 0; k < raw_q.size(); k++) begin
            b = raw_q[k];
            if (k == data_lo) begin
                data_first = line_q.size();
            end
            if (k == data_lo + 8 * nb - 1) begin
                data_last = line_q.size();
            end
            line_q.push_back(b);
            run  = (b == last) ? run + 1 : 1;
            last = b;
            if (run == 5) begin
                line_q.push_back(!b);
                last = !b;
                run  = 1;
            end
        end
        // CRC delimiter, ACK slot and delimiter, EOF, IFS
        repeat (3 + 7 + 3) begin
            line_q.push_back(1'b1);
        end
    endtask

    task automatic rand_frame(input logic need_data);
        logic [63:0] r;
        take_bits(29, r);
        cur_id = ext_id ? r[28:0] : {18'd0, r[10:0]};
        take_bits(1, r);
        cur_rtr = r[0];
        take_bits(4, r);
        cur_dlc = r[3:0];
        take_bits(64, r);
        cur_data = r;
        if (need_data) begin
            cur_rtr = 1'b0;
            if (cur_dlc == 4'd0) begin
                cur_dlc = 4'd1;
            end
        end
        build_frame();
    endtask

    task automatic send_frame(input logic flip_en, input int flip_idx);
        int i;
        int waited;
        @(posedge clk);
        tx_req  <= 1'b1;
        tx_id   <= cur_id;
        tx_rtr  <= cur_rtr;
        tx_dlc  <= cur_dlc;
        tx_data <= cur_data;
        @(negedge clk);
        waited = 0;
        while (can_tx !== 1'b0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (can_tx !== 1'b0) begin
            stop_on_error("Timeout: no SOF appeared on can_tx after tx_req");
        end
        for (i = 0; i < line_q.size(); i++) begin
            check_value($sformatf("can_tx bit %0d", i), 64'(can_tx), 64'(line_q[i]));
            check_value("tx_ack", 64'(tx_ack), 64'd0);
            @(posedge clk);
            flip <= flip_en && (i + 1 == flip_idx);
            @(negedge clk);
        end
        check_value("tx_ack", 64'(tx_ack), 64'd1);
        @(posedge clk);
        tx_req <= 1'b0;
        @(negedge clk);
        check_value("tx_ack", 64'(tx_ack), 64'd1);
        waited = 0;
        while (tx_ack !== 1'b0 && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (tx_ack !== 1'b0) begin
            stop_on_error("Timeout: tx_ack did not fall after tx_req was dropped");
        end
    endtask

    task automatic wait_rx_req(input logic required, output logic seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 40) begin
            if (rx_req === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        if (!seen && required) begin
            stop_on_error("Timeout: rx_req did not rise for a frame that should arrive");
        end
    endtask

    task automatic release_rx();
        int waited;
        @(posedge clk);
        rx_ack <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (rx_req !== 1'b0 && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (rx_req !== 1'b0) begin
            stop_on_error("Timeout: rx_req did not fall after rx_ack");
        end
        @(posedge clk);
        rx_ack <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_rx_fields(input logic [28:0] id, input logic rtr,
                                   input logic [3:0] dlc, input logic [63:0] data);
        logic [63:0] mask;
        // Bytes past the received count read as zero
        mask = ~(64'hFFFF_FFFF_FFFF_FFFF >> (8 * byte_count(rtr, dlc)));
        check_value("rx_id", 64'(rx_id), 64'(id));
        check_value("rx_rtr", 64'(rx_rtr), 64'(rtr));
        check_value("rx_dlc", 64'(rx_dlc), 64'(dlc));
        check_value("rx_data", rx_data, data & mask);
        check_value("rx_crc_err", 64'(rx_crc_err), 64'd0);
    endtask

    task automatic expect_delivery();
        logic seen;
        wait_rx_req(1'b1, seen);
        check_rx_fields(cur_id, cur_rtr, cur_dlc, cur_data);
        release_rx();
    endtask

    initial begin
        logic        seen;
        int          i;
        int          flip_idx;
        logic [63:0] r;
        rst_n   <= 1'b0;
        tx_req  <= 1'b0;
        tx_id   <= '0;
        tx_rtr  <= 1'b0;
        tx_dlc  <= '0;
        tx_data <= '0;
        rx_ack  <= 1'b0;
        flip    <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("can_tx", 64'(can_tx), 64'd1);
        check_value("tx_ack", 64'(tx_ack), 64'd0);
        check_value("rx_req", 64'(rx_req), 64'd0);

        for (i = 0; i < N_FRAMES; i++) begin
            rand_frame(1'b0);
            send_frame(1'b0, 0);
            expect_delivery();
        end

        // One inverted bit in the data field
        for (i = 0; i < N_FLIPS; i++) begin
            rand_frame(1'b1);
            take_bits(8, r);
            flip_idx = data_first + int'(r[7:0]) % (data_last - data_first + 1);
            send_frame(1'b1, flip_idx);
            wait_rx_req(1'b0, seen);
            if (seen) begin
                check_value("rx_crc_err", 64'(rx_crc_err), 64'd1);
                release_rx();
            end
        end

        // Host holds off rx_ack while a second frame goes by
        rand_frame(1'b0);
        held_id   = cur_id;
        held_rtr  = cur_rtr;
        held_dlc  = cur_dlc;
        held_data = cur_data;
        send_frame(1'b0, 0);
        wait_rx_req(1'b1, seen);
        rand_frame(1'b0);
        send_frame(1'b0, 0);
        check_value("rx_req", 64'(rx_req), 64'd1);
        check_rx_fields(held_id, held_rtr, held_dlc, held_data);
        release_rx();
        for (i = 0; i < 30; i++) begin
            check_value("rx_req", 64'(rx_req), 64'd0);
            @(negedge clk);
        end
        rand_frame(1'b0);
        send_frame(1'b0, 0);
        expect_delivery();

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- vlog.f
logic/can_pkg.sv
logic/can_frame_if.sv
logic/can_crc15.sv
logic/can_tx.sv
logic/can_rx.sv
logic/can_codec.sv
verif/can_codec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= can_codec_tb
FILELIST  ?= vlog.f
EXT_ID    ?= 0
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gext_id=$(EXT_ID) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
